// ==== Makefile ====
# Verilator build and run for the interrupt-offload engine

VERILATOR ?= verilator
TOP       ?= tb_irq_offload
FILELIST  ?= irq_offload_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== irq_offload_top.f ====
src/offload_pkg.sv
src/lite_bus_arbiter.sv
src/txfifo_reg_writer.sv
src/isr_handler.sv
src/pirq_clear.sv
src/irq_offload_top.sv
verification/tb_irq_offload.sv

// ==== src/irq_offload_top.sv ====
`timescale 1ns/1ps

module irq_offload_top (
    input  logic                               clk,
    input  logic                               reset_n,
    // Transmit command FIFO
    input  logic                               fifo_empty,
    input  logic [offload_pkg::DATA_W-1:0]     fifo_dread,
    output logic                               fifo_rd_en,
    // Interrupts
    input  logic                               irq_in,
    output logic                               irq_out,
    // Lite bus
    output logic                               lite_start,
    output offload_pkg::lite_op_t              lite_op,
    output logic [offload_pkg::ADDR_W-1:0]     lite_addr,
    output logic [offload_pkg::DATA_W-1:0]     lite_wdata,
    input  logic                               lite_idle,
    input  logic                               lite_done,
    input  logic [offload_pkg::DATA_W-1:0]     lite_rdata
);
    import offload_pkg::*;

    // ------------------------------------------------------------------------
    // Requester side of the arbiter
    // ------------------------------------------------------------------------
    logic              isr_req;
    lite_op_t          isr_op;
    logic [ADDR_W-1:0] isr_addr;
    logic [DATA_W-1:0] isr_wdata;
    logic              isr_ack;
    logic              isr_done;

    logic              tx_req;
    lite_op_t          tx_op;
    logic [ADDR_W-1:0] tx_addr;
    logic [DATA_W-1:0] tx_wdata;
    logic              tx_ack;
    logic              tx_done;

    logic              pirq_req;
    lite_op_t          pirq_op;
    logic [ADDR_W-1:0] pirq_addr;
    logic [DATA_W-1:0] pirq_wdata;
    logic              pirq_ack;
    // Bus done for the bridge clear, not the handshake below
    logic              pirq_bus_done;

    // Handler to bridge clear
    logic              pirq_start;
    logic              pirq_done;
    logic              irq_sync;

    lite_bus_arbiter u_arbiter (
        .*,
        .pirq_done (pirq_bus_done)
    );

    txfifo_reg_writer u_tx_writer (.*);

    isr_handler u_isr (.*);

    pirq_clear u_pirq (
        .*,
        .irq_in        (irq_sync),
        .pirq_done_bus (pirq_bus_done)
    );

endmodule

// ==== src/isr_handler.sv ====
`timescale 1ns/1ps

module isr_handler (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               irq_in,
    output logic                               irq_out,
    output logic                               irq_sync,
    output logic                               isr_req,
    output offload_pkg::lite_op_t              isr_op,
    output logic [offload_pkg::ADDR_W-1:0]     isr_addr,
    output logic [offload_pkg::DATA_W-1:0]     isr_wdata,
    input  logic                               isr_ack,
    input  logic                               isr_done,
    input  logic [offload_pkg::DATA_W-1:0]     lite_rdata,
    output logic                               pirq_start,
    input  logic                               pirq_done
);
    import offload_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_RD_ISR,
        S_WT_ISR,
        S_RD_S0,
        S_WT_S0,
        S_CLEAR,
        S_WT_CLEAR,
        S_PIRQ,
        S_WT_PIRQ,
        S_PASS
    } state_t;

    state_t            state;
    logic              irq_meta;
    logic              irq_prev;
    logic              pending;
    logic              owned;
    logic [DATA_W-1:0] isr_val;

    // ------------------------------------------------------------------------
    // Interrupt synchronizer and rising edge detect
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            irq_meta <= 1'b0;
            irq_sync <= 1'b0;
            irq_prev <= 1'b0;
        end else begin
            irq_meta <= irq_in;
            irq_sync <= irq_meta;
            irq_prev <= irq_sync;
        end
    end

    // ------------------------------------------------------------------------
    // Service FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= S_IDLE;
            pending <= 1'b0;
            owned   <= 1'b0;
            irq_out <= 1'b0;
        end else begin
            // A new edge wins over the clear so it is never lost
            if (irq_sync && !irq_prev) begin
                pending <= 1'b1;
            end else if (state == S_IDLE) begin
                pending <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (pending) begin
                        owned <= 1'b0;
                        state <= S_RD_ISR;
                    end
                end
                S_RD_ISR: if (isr_ack) state <= S_WT_ISR;
                S_WT_ISR: begin
                    if (isr_done) begin
                        state <= ((lite_rdata & ISR_TXOK) != '0) ? S_RD_S0 : S_CLEAR;
                    end
                end
                S_RD_S0:  if (isr_ack) state <= S_WT_S0;
                S_WT_S0: begin
                    if (isr_done) begin
                        owned <= (lite_rdata == FPGA_QCU);
                        state <= S_CLEAR;
                    end
                end
                S_CLEAR:  if (isr_ack) state <= S_WT_CLEAR;
                S_WT_CLEAR: begin
                    if (isr_done) begin
                        // Nothing left for the host, so clear the bridge instead
                        if (owned && isr_val == ISR_TXOK) begin
                            state <= S_PIRQ;
                        end else begin
                            irq_out <= 1'b1;
                            state   <= S_PASS;
                        end
                    end
                end
                S_PIRQ:    state <= S_WT_PIRQ;
                S_WT_PIRQ: if (pirq_done) state <= S_IDLE;
                S_PASS: begin
                    // Host owns it until the NIC line drops
                    if (!irq_sync) begin
                        irq_out <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WT_ISR && isr_done) begin
            isr_val <= lite_rdata;
        end
    end

    // Bus command follows the state
    assign isr_req    = (state == S_RD_ISR) || (state == S_RD_S0) || (state == S_CLEAR);
    assign isr_op     = (state == S_CLEAR) ? LITE_WR : LITE_RD;
    assign isr_addr   = NIC_BASE + ((state == S_RD_S0) ? AR_ISR_S0 : AR_ISR);
    assign isr_wdata  = owned ? ISR_TXOK : '0;
    assign pirq_start = (state == S_PIRQ);

    a_pass_or_clear: assert property (@(posedge clk) disable iff (!reset_n)
        !(irq_out && pirq_start));

endmodule

// ==== src/lite_bus_arbiter.sv ====
`timescale 1ns/1ps

module lite_bus_arbiter (
    input  logic                               clk,
    input  logic                               reset_n,
    // Interrupt handler, highest priority
    input  logic                               isr_req,
    input  offload_pkg::lite_op_t              isr_op,
    input  logic [offload_pkg::ADDR_W-1:0]     isr_addr,
    input  logic [offload_pkg::DATA_W-1:0]     isr_wdata,
    output logic                               isr_ack,
    output logic                               isr_done,
    // Transmit register writer
    input  logic                               tx_req,
    input  offload_pkg::lite_op_t              tx_op,
    input  logic [offload_pkg::ADDR_W-1:0]     tx_addr,
    input  logic [offload_pkg::DATA_W-1:0]     tx_wdata,
    output logic                               tx_ack,
    output logic                               tx_done,
    // Bridge clear, lowest priority
    input  logic                               pirq_req,
    input  offload_pkg::lite_op_t              pirq_op,
    input  logic [offload_pkg::ADDR_W-1:0]     pirq_addr,
    input  logic [offload_pkg::DATA_W-1:0]     pirq_wdata,
    output logic                               pirq_ack,
    output logic                               pirq_done,
    // Lite bus
    output logic                               lite_start,
    output offload_pkg::lite_op_t              lite_op,
    output logic [offload_pkg::ADDR_W-1:0]     lite_addr,
    output logic [offload_pkg::DATA_W-1:0]     lite_wdata,
    input  logic                               lite_idle,
    input  logic                               lite_done
);
    import offload_pkg::*;

    logic [N_REQ-1:0] req;
    logic [N_REQ-1:0] grant;
    logic [N_REQ-1:0] owner;
    logic [N_REQ-1:0] ack;
    logic             busy;
    logic             win;

    assign req = {pirq_req, tx_req, isr_req};

    // Lowest set bit wins, so bit 0 (isr) has top priority
    assign grant = req & ~(req - 1'b1);
    assign win   = !busy && lite_idle && (|req);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            owner      <= '0;
            ack        <= '0;
            lite_start <= 1'b0;
        end else begin
            lite_start <= win;
            ack        <= win ? grant : '0;
            if (win) begin
                busy  <= 1'b1;
                owner <= grant;
            end else if (lite_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Winner's command onto the bus
    always_ff @(posedge clk) begin
        if (win) begin
            if (grant[0]) begin
                lite_op    <= isr_op;
                lite_addr  <= isr_addr;
                lite_wdata <= isr_wdata;
            end else if (grant[1]) begin
                lite_op    <= tx_op;
                lite_addr  <= tx_addr;
                lite_wdata <= tx_wdata;
            end else begin
                lite_op    <= pirq_op;
                lite_addr  <= pirq_addr;
                lite_wdata <= pirq_wdata;
            end
        end
    end

    assign {pirq_ack, tx_ack, isr_ack} = ack;

    // Done goes back to the owner only, same cycle
    assign isr_done  = busy && owner[0] && lite_done;
    assign tx_done   = busy && owner[1] && lite_done;
    assign pirq_done = busy && owner[2] && lite_done;

    // No second start until the outstanding transaction is done
    a_no_start_busy: assert property (@(posedge clk) disable iff (!reset_n)
        busy |=> !lite_start);

    a_ack_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({isr_ack, tx_ack, pirq_ack}));

endmodule

// ==== src/offload_pkg.sv ====
package offload_pkg;

    // ------------------------------------------------------------------------
    // Bus geometry and operation codes
    // ------------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Requesters on the lite bus: isr, tx, pirq
    localparam int N_REQ = 3;

    typedef enum logic {
        LITE_RD = 1'b0,
        LITE_WR = 1'b1
    } lite_op_t;

    // ------------------------------------------------------------------------
    // NIC register window
    // ------------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] NIC_BASE  = 32'h6000_0000;
    localparam logic [ADDR_W-1:0] AR_ISR    = 32'h0000_0080;
    // Per-queue transmit-OK status
    localparam logic [ADDR_W-1:0] AR_ISR_S0 = 32'h0000_0084;

    localparam logic [DATA_W-1:0] ISR_TXOK  = 32'h0000_0040;
    // S0 pattern when only the FPGA queue completed
    localparam logic [DATA_W-1:0] FPGA_QCU  = 32'h0000_0040;

    // ------------------------------------------------------------------------
    // PCIe bridge interrupt registers
    // ------------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] PCIE_BASE       = 32'h5000_0000;
    localparam logic [ADDR_W-1:0] PCIE_INT_DECODE = 32'h0000_0138;
    localparam logic [ADDR_W-1:0] PCIE_INT_FIFO   = 32'h0000_0158;

    localparam logic [DATA_W-1:0] PCIE_DECODE_CLR = 32'h0001_0000;
    localparam logic [DATA_W-1:0] PCIE_FIFO_CLR   = 32'hffff_ffff;

endpackage

// ==== src/pirq_clear.sv ====
`timescale 1ns/1ps

module pirq_clear (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               pirq_start,
    output logic                               pirq_done,
    input  logic                               irq_in,
    output logic                               pirq_req,
    output offload_pkg::lite_op_t              pirq_op,
    output logic [offload_pkg::ADDR_W-1:0]     pirq_addr,
    output logic [offload_pkg::DATA_W-1:0]     pirq_wdata,
    input  logic                               pirq_ack,
    input  logic                               pirq_done_bus
);
    import offload_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DEC_REQ,
        S_DEC_WAIT,
        S_FIFO_REQ,
        S_FIFO_WAIT,
        S_DONE
    } state_t;

    state_t state;
    logic   fifo_phase;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:     if (pirq_start) state <= S_DEC_REQ;
                S_DEC_REQ:  if (pirq_ack) state <= S_DEC_WAIT;
                S_DEC_WAIT: if (pirq_done_bus) state <= S_FIFO_REQ;
                S_FIFO_REQ: if (pirq_ack) state <= S_FIFO_WAIT;
                S_FIFO_WAIT: begin
                    // Line still up, clear the pair again
                    if (pirq_done_bus) begin
                        state <= irq_in ? S_DEC_REQ : S_DONE;
                    end
                end
                S_DONE:     state <= S_IDLE;
                default:    state <= S_IDLE;
            endcase
        end
    end

    assign fifo_phase = (state == S_FIFO_REQ) || (state == S_FIFO_WAIT);

    assign pirq_req   = (state == S_DEC_REQ) || (state == S_FIFO_REQ);
    assign pirq_op    = LITE_WR;
    assign pirq_addr  = PCIE_BASE + (fifo_phase ? PCIE_INT_FIFO : PCIE_INT_DECODE);
    assign pirq_wdata = fifo_phase ? PCIE_FIFO_CLR : PCIE_DECODE_CLR;
    assign pirq_done  = (state == S_DONE);

endmodule

// ==== src/txfifo_reg_writer.sv ====
`timescale 1ns/1ps

module txfifo_reg_writer (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               fifo_empty,
    input  logic [offload_pkg::DATA_W-1:0]     fifo_dread,
    output logic                               fifo_rd_en,
    output logic                               tx_req,
    output offload_pkg::lite_op_t              tx_op,
    output logic [offload_pkg::ADDR_W-1:0]     tx_addr,
    output logic [offload_pkg::DATA_W-1:0]     tx_wdata,
    input  logic                               tx_ack,
    input  logic                               tx_done
);
    import offload_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_TAKE_ADDR,
        S_WAIT_DATA,
        S_TAKE_DATA,
        S_REQUEST,
        S_WAIT_DONE
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:      if (!fifo_empty) state <= S_TAKE_ADDR;
                S_TAKE_ADDR: state <= S_WAIT_DATA;
                // Data word may lag behind the address
                S_WAIT_DATA: if (!fifo_empty) state <= S_TAKE_DATA;
                S_TAKE_DATA: state <= S_REQUEST;
                S_REQUEST:   if (tx_ack) state <= S_WAIT_DONE;
                S_WAIT_DONE: if (tx_done) state <= S_IDLE;
                default:     state <= S_IDLE;
            endcase
        end
    end

    // First word is the register address, second the write data
    always_ff @(posedge clk) begin
        if (state == S_TAKE_ADDR) begin
            tx_addr <= fifo_dread;
        end
        if (state == S_TAKE_DATA) begin
            tx_wdata <= fifo_dread;
        end
    end

    // FWFT, so the word is consumed in the cycle it is latched
    assign fifo_rd_en = (state == S_TAKE_ADDR) || (state == S_TAKE_DATA);
    assign tx_req     = (state == S_REQUEST);
    assign tx_op      = LITE_WR;

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        fifo_rd_en |-> !fifo_empty);

endmodule

// ==== verification/tb_irq_offload.sv ====
`timescale 1ns/1ps

module tb_irq_offload;
    import offload_pkg::*;

    // About 22 transactions of at most 12 cycles each, quiet windows, wide margin
    localparam int CYCLE_LIMIT = 4000;

    logic              clk;
    logic              reset_n;
    logic              fifo_empty;
    logic [DATA_W-1:0] fifo_dread;
    logic              fifo_rd_en;
    logic              irq_in;
    logic              irq_out;
    logic              lite_start;
    lite_op_t          lite_op;
    logic [ADDR_W-1:0] lite_addr;
    logic [DATA_W-1:0] lite_wdata;
    logic              lite_idle;
    logic              lite_done;
    logic [DATA_W-1:0] lite_rdata;

    logic [31:0]       lfsr;
    logic [DATA_W-1:0] isr_status;
    logic [DATA_W-1:0] s0_status;
    logic              bus_busy;
    logic              expect_quiet;
    logic [DATA_W-1:0] fifo_q[$];
    lite_op_t          log_op[$];
    logic [ADDR_W-1:0] log_addr[$];
    logic [DATA_W-1:0] log_data[$];
    logic [ADDR_W-1:0] addr_a;
    logic [DATA_W-1:0] data_d;
    int                base;
    int                errors;
    int                checks;
    int                cycles;

    irq_offload_top dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5;
            clk = ~clk;
        end
    end

    // ------------------------------------------------------------------------
    // Random source, FIFO model and lite-bus slave
    // ------------------------------------------------------------------------
    function automatic logic next_random_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'hd000_0001;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_random_bit()};
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] read_value(input logic [ADDR_W-1:0] addr);
        if (addr == NIC_BASE + AR_ISR) return isr_status;
        if (addr == NIC_BASE + AR_ISR_S0) return s0_status;
        return '0;
    endfunction

    function automatic void refresh_fifo();
        fifo_empty = (fifo_q.size() == 0);
        fifo_dread = fifo_empty ? '0 : fifo_q[0];
    endfunction

    task automatic push_word(input logic [DATA_W-1:0] word);
        fifo_q.push_back(word);
        refresh_fifo();
    endtask

    // FWFT pop, applied just after the edge that consumed the word
    initial begin : fifo_model
        logic popping;
        forever begin
            @(negedge clk);
            popping = reset_n && fifo_rd_en;
            @(posedge clk);
            #1;
            if (popping) begin
                fifo_q.delete(0);
            end
            refresh_fifo();
        end
    end

    initial begin : lite_slave
        lite_op_t op;
        int       delay;
        forever begin
            @(negedge clk);
            if (reset_n && lite_start) begin
                op = lite_op;
                log_op.push_back(lite_op);
                log_addr.push_back(lite_addr);
                log_data.push_back((op == LITE_WR) ? lite_wdata : read_value(lite_addr));
                delay = 2 + int'(random_bits(3));
                @(posedge clk);
                #1;
                lite_idle = 1'b0;
                bus_busy  = 1'b1;
                repeat (delay - 1) @(posedge clk);
                #1;
                lite_rdata = (op == LITE_RD) ? log_data[log_data.size() - 1] : '0;
                lite_done  = 1'b1;
                @(posedge clk);
                #1;
                lite_done  = 1'b0;
                lite_rdata = '0;
                lite_idle  = 1'b1;
                bus_busy   = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Protocol assertions
    // ------------------------------------------------------------------------
    a_one_outstanding: assert property (@(negedge clk) disable iff (!reset_n)
        lite_start |-> !bus_busy)
        else begin
            errors++;
            $display("Lite start issued while a transaction was outstanding");
        end

    a_owned_quiet: assert property (@(negedge clk) disable iff (!reset_n)
        expect_quiet |-> !irq_out)
        else begin
            errors++;
            $display("Interrupt passed to the host for an owned completion");
        end

    // Two sync stages plus the release register
    a_irq_released: assert property (@(negedge clk) disable iff (!reset_n)
        (!irq_in && !$past(irq_in) && !$past(irq_in, 2) && !$past(irq_in, 3)) |-> !irq_out)
        else begin
            errors++;
            $display("Host interrupt still high after the NIC line dropped");
        end

    // ------------------------------------------------------------------------
    // Log checks and waits
    // ------------------------------------------------------------------------
    task automatic check_txn(input string name, input int idx, input lite_op_t op,
                             input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        checks++;
        if (idx >= log_addr.size()) begin
            errors++;
            $display("Transaction %0d of %s never reached the bus", idx, name);
        end else begin
            assert (log_op[idx] == op && log_addr[idx] == addr &&
                    (op == LITE_RD || log_data[idx] == data))
            else begin
                errors++;
                $display("Fail %s: expected %s %h data %h, actual %s %h data %h", name,
                         op.name(), addr, data, log_op[idx].name(), log_addr[idx],
                         log_data[idx]);
            end
        end
    endtask

    task automatic check_count(input string name, input int expected);
        checks++;
        assert (log_addr.size() == expected)
        else begin
            errors++;
            $display("Fail %s: expected %0d transactions, actual %0d", name, expected,
                     log_addr.size());
        end
    endtask

    task automatic check_bridge_pair(input string name, input int idx);
        check_txn(name, idx, LITE_WR, PCIE_BASE + PCIE_INT_DECODE, PCIE_DECODE_CLR);
        check_txn(name, idx + 1, LITE_WR, PCIE_BASE + PCIE_INT_FIFO, PCIE_FIFO_CLR);
    endtask

    task automatic check_status_clear(input string name, input int idx);
        check_txn(name, idx, LITE_RD, NIC_BASE + AR_ISR, '0);
        check_txn(name, idx + 1, LITE_RD, NIC_BASE + AR_ISR_S0, '0);
        check_txn(name, idx + 2, LITE_WR, NIC_BASE + AR_ISR, ISR_TXOK);
    endtask

    // Exactly one write to addr from the given log index on
    task automatic check_tx_write(input string name, input int from,
                                  input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int hits;
        int where;
        hits  = 0;
        where = from;
        for (int i = from; i < log_addr.size(); i++) begin
            if (log_op[i] == LITE_WR && log_addr[i] == addr) begin
                hits++;
                where = i;
            end
        end
        checks++;
        assert (hits == 1)
        else begin
            errors++;
            $display("Fail %s: expected 1 write to %h, actual %0d", name, addr, hits);
        end
        check_txn(name, where, LITE_WR, addr, data);
    endtask

    task automatic await_log(input int count, input int limit, input string what);
        int n;
        n = 0;
        while (log_addr.size() < count && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (log_addr.size() < count) begin
            errors++;
            $display("Timed out waiting for the %s", what);
        end
    endtask

    task automatic await_irq_out(input logic level, input int limit);
        int n;
        n = 0;
        while (irq_out != level && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (irq_out != level) begin
            errors++;
            $display("Timed out waiting for irq_out to go %b", level);
        end
    endtask

    // Bus quiet for 16 cycles in a row
    task automatic settle(input int limit);
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 16 && n < limit) begin
            @(posedge clk);
            #1;
            n++;
            quiet = (bus_busy || lite_start || !lite_idle) ? 0 : quiet + 1;
        end
        if (quiet < 16) begin
            errors++;
            $display("Lite bus never went quiet");
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        reset_n      = 1'b0;
        irq_in       = 1'b0;
        fifo_empty   = 1'b1;
        fifo_dread   = '0;
        lite_idle    = 1'b1;
        lite_done    = 1'b0;
        lite_rdata   = '0;
        lfsr         = 32'hd286;
        isr_status   = '0;
        s0_status    = '0;
        bus_busy     = 1'b0;
        expect_quiet = 1'b0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;
        checks++;
        assert (!lite_start && !fifo_rd_en && !irq_out)
        else begin
            errors++;
            $display("Outputs not idle right after reset");
        end

        // Transmit pair
        base   = log_addr.size();
        addr_a = 32'h6000_1000 + (random_bits(8) << 2);
        data_d = random_bits(32);
        push_word(addr_a);
        push_word(data_d);
        await_log(base + 1, 100, "transmit write");
        settle(200);
        check_count("tx_pair", base + 1);
        check_tx_write("tx_pair", base, addr_a, data_d);

        // Owned completion, line drops after the first bridge write
        isr_status   = ISR_TXOK;
        s0_status    = FPGA_QCU;
        expect_quiet = 1'b1;
        base         = log_addr.size();
        irq_in       = 1'b1;
        await_log(base + 4, 200, "first bridge write");
        irq_in = 1'b0;
        settle(300);
        expect_quiet = 1'b0;
        check_count("owned_txok", base + 5);
        check_status_clear("owned_txok", base);
        check_bridge_pair("owned_txok", base + 3);

        // Extra status bit stays with the host
        isr_status = ISR_TXOK | 32'h0000_0001;
        base       = log_addr.size();
        irq_in     = 1'b1;
        await_irq_out(1'b1, 300);
        check_count("host_irq", base + 3);
        check_status_clear("host_irq", base);
        irq_in = 1'b0;
        await_irq_out(1'b0, 20);
        settle(100);
        check_count("host_irq", base + 3);

        // Line held through the first clear pair
        isr_status   = ISR_TXOK;
        expect_quiet = 1'b1;
        base         = log_addr.size();
        irq_in       = 1'b1;
        await_log(base + 6, 300, "second bridge decode clear");
        irq_in = 1'b0;
        settle(300);
        check_count("persistent_irq", base + 7);
        check_status_clear("persistent_irq", base);
        check_bridge_pair("persistent_irq", base + 3);
        check_bridge_pair("persistent_irq", base + 5);

        // Transmit pair and interrupt edge in the same cycle
        base   = log_addr.size();
        addr_a = 32'h6000_2000 + (random_bits(8) << 2);
        data_d = random_bits(32);
        push_word(addr_a);
        push_word(data_d);
        irq_in = 1'b1;
        await_log(base + 3, 300, "status clear write");
        irq_in = 1'b0;
        settle(400);
        expect_quiet = 1'b0;
        check_count("contention", base + 6);
        check_txn("contention", base, LITE_RD, NIC_BASE + AR_ISR, '0);
        check_tx_write("contention", base, addr_a, data_d);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
